// ==== Bender.yml ====
package:
  name: biquad

sources:
  - rtl/biquad_cfg_pkg.sv
  - rtl/biquad_types_pkg.sv
  - rtl/coeff_if.sv
  - rtl/coeff_ctrl.sv
  - rtl/zero_fir.sv
  - rtl/pole_iir.sv
  - rtl/biquad_top.sv
  - target: test
    files:
      - test/biquad_assertions.sv
      - test/biquad_tb.sv

// ==== project.f ====
rtl/biquad_cfg_pkg.sv
rtl/biquad_types_pkg.sv
rtl/coeff_if.sv
rtl/coeff_ctrl.sv
rtl/zero_fir.sv
rtl/pole_iir.sv
rtl/biquad_top.sv
test/biquad_assertions.sv
test/biquad_tb.sv

// ==== rtl/biquad_cfg_pkg.sv ====
package biquad_cfg_pkg;

    // register bus geometry
    localparam int adr_w = 5;
    localparam int reg_w = 32;

    // coefficients are signed Q4.14
    localparam int coeff_w    = 18;
    localparam int coeff_frac = 14;
    localparam logic signed [coeff_w-1:0] coeff_one = 18'sd16384;

    // extra bits on top of the sample width for the three-tap sum after the shift
    localparam int guard_w = coeff_w + 2 - coeff_frac;

    // word-aligned register map
    localparam logic [adr_w-1:0] adr_ctrl = 5'h00;
    localparam logic [adr_w-1:0] adr_b0   = 5'h04;
    localparam logic [adr_w-1:0] adr_b1   = 5'h08;
    localparam logic [adr_w-1:0] adr_b2   = 5'h0C;
    localparam logic [adr_w-1:0] adr_a1   = 5'h10;
    localparam logic [adr_w-1:0] adr_a2   = 5'h14;

    // which coefficient a write is aimed at
    typedef enum logic [2:0] {
        sel_b0,
        sel_b1,
        sel_b2,
        sel_a1,
        sel_a2
    } coeff_sel_e;

endpackage

// ==== rtl/biquad_top.sv ====
`timescale 1ns/10ps

module biquad_top #(
    parameter int DATA_W = 16
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // register write port
    input  logic                              reg_wr_i,
    input  logic [biquad_cfg_pkg::adr_w-1:0]  reg_adr_i,
    input  logic [biquad_cfg_pkg::reg_w-1:0]  reg_dat_i,
    input  logic                              global_update_i,

    // sample stream
    input  logic                              dat_valid_i,
    input  logic signed [DATA_W-1:0]          dat_i,
    output logic                              dat_valid_o,
    output logic signed [DATA_W-1:0]          dat_o
);

    // zero section result, one cycle behind dat_valid_i
    logic                                             w_valid;
    logic signed [DATA_W+biquad_cfg_pkg::guard_w-1:0] w;

    // one strobe bus shared by both stages
    coeff_if coeff_bus ();

    coeff_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .reg_wr_i        (reg_wr_i),
        .reg_adr_i       (reg_adr_i),
        .reg_dat_i       (reg_dat_i),
        .global_update_i (global_update_i),
        .coeff_o         (coeff_bus.ctrl)
    );

    zero_fir #(
        .DATA_W (DATA_W)
    ) u_zero (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .coeff_i     (coeff_bus.stage),
        .dat_valid_i (dat_valid_i),
        .dat_i       (dat_i),
        .w_valid_o   (w_valid),
        .w_o         (w)
    );

    pole_iir #(
        .DATA_W (DATA_W)
    ) u_pole (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .coeff_i     (coeff_bus.stage),
        .w_valid_i   (w_valid),
        .w_i         (w),
        .dat_valid_o (dat_valid_o),
        .dat_o       (dat_o)
    );

endmodule

// ==== rtl/biquad_types_pkg.sv ====
package biquad_types_pkg;

    // control register layout, only bit 0 is live
    typedef struct packed {
        logic [biquad_cfg_pkg::reg_w-2:0] reserved;
        logic                             update;
    } ctrl_view_t;

    // coefficient register layout, upper bits ignored
    typedef struct packed {
        logic [biquad_cfg_pkg::reg_w-biquad_cfg_pkg::coeff_w-1:0] unused;
        logic signed [biquad_cfg_pkg::coeff_w-1:0]                coeff;
    } coeff_view_t;

    // one register data word, read as control or coefficient by address
    typedef union packed {
        ctrl_view_t  ctrl;
        coeff_view_t coeff;
    } reg_word_u;

endpackage

// ==== rtl/coeff_ctrl.sv ====
`timescale 1ns/10ps

module coeff_ctrl (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              reg_wr_i,
    input  logic [biquad_cfg_pkg::adr_w-1:0]  reg_adr_i,
    input  logic [biquad_cfg_pkg::reg_w-1:0]  reg_dat_i,
    input  logic                              global_update_i,
    coeff_if.ctrl                             coeff_o
);

    biquad_types_pkg::reg_word_u word;
    biquad_cfg_pkg::coeff_sel_e  sel_nxt;
    logic                        hit_coeff;
    logic                        hit_ctrl;

    assign word = reg_dat_i;

    // address decode, the only place the map is compared
    always_comb begin
        hit_coeff = 1'b1;
        hit_ctrl  = 1'b0;
        sel_nxt   = biquad_cfg_pkg::sel_b0;
        case (reg_adr_i)
            biquad_cfg_pkg::adr_ctrl: begin
                hit_coeff = 1'b0;
                hit_ctrl  = 1'b1;
            end
            biquad_cfg_pkg::adr_b0: sel_nxt = biquad_cfg_pkg::sel_b0;
            biquad_cfg_pkg::adr_b1: sel_nxt = biquad_cfg_pkg::sel_b1;
            biquad_cfg_pkg::adr_b2: sel_nxt = biquad_cfg_pkg::sel_b2;
            biquad_cfg_pkg::adr_a1: sel_nxt = biquad_cfg_pkg::sel_a1;
            biquad_cfg_pkg::adr_a2: sel_nxt = biquad_cfg_pkg::sel_a2;
            // unmapped, drop the write
            default: hit_coeff = 1'b0;
        endcase
    end

    // strobes, one cycle after the request
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            coeff_o.wr     <= 1'b0;
            coeff_o.update <= 1'b0;
        end else begin
            coeff_o.wr     <= reg_wr_i && hit_coeff;
            coeff_o.update <= global_update_i ||
                              (reg_wr_i && hit_ctrl && word.ctrl.update);
        end
    end

    // payload only moves on a coefficient write
    always_ff @(posedge clk_i) begin
        if (reg_wr_i && hit_coeff) begin
            coeff_o.coeff <= word.coeff.coeff;
            coeff_o.sel   <= sel_nxt;
        end
    end

endmodule

// ==== rtl/coeff_if.sv ====
`timescale 1ns/10ps

interface coeff_if;

    // coefficient payload and its target
    logic signed [biquad_cfg_pkg::coeff_w-1:0] coeff;
    biquad_cfg_pkg::coeff_sel_e                sel;

    // single-cycle strobes
    logic wr;
    logic update;

    modport ctrl (
        output coeff,
        output sel,
        output wr,
        output update
    );

    modport stage (
        input coeff,
        input sel,
        input wr,
        input update
    );

endinterface

// ==== rtl/pole_iir.sv ====
`timescale 1ns/10ps

module pole_iir #(
    parameter int DATA_W = 16
) (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    coeff_if.stage                                            coeff_i,
    input  logic                                              w_valid_i,
    input  logic signed [DATA_W+biquad_cfg_pkg::guard_w-1:0]  w_i,
    output logic                                              dat_valid_o,
    output logic signed [DATA_W-1:0]                          dat_o
);

    localparam int W_W   = DATA_W + biquad_cfg_pkg::guard_w;
    localparam int FB_W  = DATA_W + biquad_cfg_pkg::coeff_w + 1;
    localparam int FBQ_W = FB_W - biquad_cfg_pkg::coeff_frac;
    localparam int Y_W   = W_W + 1;

    // index 0 is a1, index 1 is a2
    logic signed [biquad_cfg_pkg::coeff_w-1:0] shadow [2];
    logic signed [biquad_cfg_pkg::coeff_w-1:0] active [2];

    logic signed [DATA_W-1:0] y2;
    logic signed [FB_W-1:0]   fb;
    logic signed [FBQ_W-1:0]  fb_q;
    logic signed [Y_W-1:0]    y_full;
    logic signed [DATA_W-1:0] y_sat;
    logic                     ovf;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            shadow[0] <= '0;
            shadow[1] <= '0;
            active[0] <= '0;
            active[1] <= '0;
        end else begin
            if (coeff_i.wr) begin
                case (coeff_i.sel)
                    biquad_cfg_pkg::sel_a1: shadow[0] <= coeff_i.coeff;
                    biquad_cfg_pkg::sel_a2: shadow[1] <= coeff_i.coeff;
                    default: ;
                endcase
            end
            if (coeff_i.update) begin
                active <= shadow;
            end
        end
    end

    // feedback sum, dat_o doubles as the previous y
    always_comb begin
        fb     = active[0] * dat_o + active[1] * y2;
        fb_q   = fb[FB_W-1:biquad_cfg_pkg::coeff_frac];
        y_full = w_i - fb_q;
    end

    // overflow when the bits above the sign of DATA_W disagree
    always_comb begin
        ovf = (y_full[Y_W-1:DATA_W-1] != {(Y_W-DATA_W+1){y_full[Y_W-1]}});
        if (!ovf) begin
            y_sat = y_full[DATA_W-1:0];
        end else if (y_full[Y_W-1]) begin
            y_sat = {1'b1, {(DATA_W-1){1'b0}}};
        end else begin
            y_sat = {1'b0, {(DATA_W-1){1'b1}}};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dat_valid_o <= 1'b0;
            dat_o       <= '0;
            y2          <= '0;
        end else begin
            dat_valid_o <= w_valid_i;
            if (w_valid_i) begin
                dat_o <= y_sat;
                y2    <= dat_o;
            end
        end
    end

endmodule

// ==== rtl/zero_fir.sv ====
`timescale 1ns/10ps

module zero_fir #(
    parameter int DATA_W = 16
) (
    input  logic                                              clk_i,
    input  logic                                              rst_n_i,
    coeff_if.stage                                            coeff_i,
    input  logic                                              dat_valid_i,
    input  logic signed [DATA_W-1:0]                          dat_i,
    output logic                                              w_valid_o,
    output logic signed [DATA_W+biquad_cfg_pkg::guard_w-1:0]  w_o
);

    localparam int SUM_W = DATA_W + biquad_cfg_pkg::coeff_w + 2;

    // index 0..2 holds b0..b2
    logic signed [biquad_cfg_pkg::coeff_w-1:0] shadow [3];
    logic signed [biquad_cfg_pkg::coeff_w-1:0] active [3];

    logic signed [DATA_W-1:0] x1;
    logic signed [DATA_W-1:0] x2;
    logic signed [SUM_W-1:0]  acc;

    // shadow takes our own writes, active copies on update
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            shadow[0] <= biquad_cfg_pkg::coeff_one;
            shadow[1] <= '0;
            shadow[2] <= '0;
            active[0] <= biquad_cfg_pkg::coeff_one;
            active[1] <= '0;
            active[2] <= '0;
        end else begin
            if (coeff_i.wr) begin
                case (coeff_i.sel)
                    biquad_cfg_pkg::sel_b0: shadow[0] <= coeff_i.coeff;
                    biquad_cfg_pkg::sel_b1: shadow[1] <= coeff_i.coeff;
                    biquad_cfg_pkg::sel_b2: shadow[2] <= coeff_i.coeff;
                    default: ;
                endcase
            end
            if (coeff_i.update) begin
                active <= shadow;
            end
        end
    end

    // full precision three-tap sum
    always_comb begin
        acc = active[0] * dat_i + active[1] * x1 + active[2] * x2;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            x1        <= '0;
            x2        <= '0;
            w_valid_o <= 1'b0;
            w_o       <= '0;
        end else begin
            w_valid_o <= dat_valid_i;
            if (dat_valid_i) begin
                x1  <= dat_i;
                x2  <= x1;
                // dropping the low bits is the arithmetic shift by coeff_frac
                w_o <= acc[SUM_W-1:biquad_cfg_pkg::coeff_frac];
            end
        end
    end

endmodule

// ==== test/biquad_assertions.sv ====
`timescale 1ns/10ps

module biquad_assertions #(
    parameter bit FOLLOW = 1'b0
) (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_i,
    input logic strobe_i
);

    // every strobe traces back to a request one cycle earlier
    // so a single request never gives a stretched pulse
    a_no_orphan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        strobe_i |-> $past(req_i))
        else $error("strobe without a request in the previous cycle");

    a_reset_low: assert property (@(posedge clk_i) !rst_n_i |=> !strobe_i)
        else $error("strobe high while in reset");

    // data valid must always come through
    if (FOLLOW) begin : g_follow
        a_follow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            req_i |=> strobe_i)
            else $error("output valid missing one cycle after input valid");
    end

endmodule

bind coeff_ctrl biquad_assertions u_wr_chk (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (reg_wr_i),
    .strobe_i (coeff_o.wr)
);

bind coeff_ctrl biquad_assertions u_update_chk (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (reg_wr_i || global_update_i),
    .strobe_i (coeff_o.update)
);

bind pole_iir biquad_assertions #(.FOLLOW(1'b1)) u_valid_chk (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (w_valid_i),
    .strobe_i (dat_valid_o)
);

// ==== test/biquad_tb.sv ====
`timescale 1ns/10ps

module biquad_tb;

    localparam int DATA_W       = 16;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_CYCLES  = 20;

    // coefficient registers in map order b0, b1, b2, a1, a2
    localparam logic [biquad_cfg_pkg::adr_w-1:0] COEFF_ADR [5] = '{
        biquad_cfg_pkg::adr_b0, biquad_cfg_pkg::adr_b1, biquad_cfg_pkg::adr_b2,
        biquad_cfg_pkg::adr_a1, biquad_cfg_pkg::adr_a2
    };

    logic                             clk_i;
    logic                             rst_n_i;
    logic                             reg_wr_i;
    logic [biquad_cfg_pkg::adr_w-1:0] reg_adr_i;
    logic [biquad_cfg_pkg::reg_w-1:0] reg_dat_i;
    logic                             global_update_i;
    logic                             dat_valid_i;
    logic signed [DATA_W-1:0]         dat_i;
    logic                             dat_valid_o;
    logic signed [DATA_W-1:0]         dat_o;

    // model of the coefficient sets and of the filter history
    logic signed [biquad_cfg_pkg::coeff_w-1:0] shadow_b [3];
    logic signed [biquad_cfg_pkg::coeff_w-1:0] active_b [3];
    logic signed [biquad_cfg_pkg::coeff_w-1:0] shadow_a [2];
    logic signed [biquad_cfg_pkg::coeff_w-1:0] active_a [2];
    longint hist_x1;
    longint hist_x2;
    longint hist_y1;
    longint hist_y2;

    logic [15:0]              lfsr_state;
    logic signed [DATA_W-1:0] exp_q [$];

    biquad_top #(
        .DATA_W (DATA_W)
    ) dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .reg_wr_i        (reg_wr_i),
        .reg_adr_i       (reg_adr_i),
        .reg_dat_i       (reg_dat_i),
        .global_update_i (global_update_i),
        .dat_valid_i     (dat_valid_i),
        .dat_i           (dat_i),
        .dat_valid_o     (dat_valid_o),
        .dat_o           (dat_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopping after a failed check");
    endtask

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // half within +-1.0, half over the full +-8 range
    function automatic int rand_coeff();
        logic [31:0] r;
        int          c;
        r = rand_bits(19);
        if (r[18]) begin
            c = $signed(r[17:0]);
        end else begin
            c = $signed(r[14:0]);
        end
        return c;
    endfunction

    function automatic void model_reset();
        shadow_b = '{biquad_cfg_pkg::coeff_one, '0, '0};
        active_b = '{biquad_cfg_pkg::coeff_one, '0, '0};
        shadow_a = '{'0, '0};
        active_a = '{'0, '0};
        hist_x1 = 0;
        hist_x2 = 0;
        hist_y1 = 0;
        hist_y2 = 0;
    endfunction

    function automatic void model_update();
        active_b = shadow_b;
        active_a = shadow_a;
    endfunction

    // register map as the filter decodes it
    function automatic void model_write(input logic [biquad_cfg_pkg::adr_w-1:0] adr,
                                        input logic [31:0] data);
        case (adr)
            biquad_cfg_pkg::adr_ctrl: begin
                if (data[0]) begin
                    model_update();
                end
            end
            biquad_cfg_pkg::adr_b0: shadow_b[0] = data[17:0];
            biquad_cfg_pkg::adr_b1: shadow_b[1] = data[17:0];
            biquad_cfg_pkg::adr_b2: shadow_b[2] = data[17:0];
            biquad_cfg_pkg::adr_a1: shadow_a[0] = data[17:0];
            biquad_cfg_pkg::adr_a2: shadow_a[1] = data[17:0];
            default: ;
        endcase
    endfunction

    // expected biquad output for input x from the model history
    function automatic logic signed [DATA_W-1:0] ref_filter(input longint x);
        longint w;
        longint fb;
        longint y;
        longint y_max;
        longint y_min;
        y_max = (longint'(1) <<< (DATA_W - 1)) - 1;
        y_min = -y_max - 1;
        w = (active_b[0] * x + active_b[1] * hist_x1 + active_b[2] * hist_x2)
            >>> biquad_cfg_pkg::coeff_frac;
        fb = (active_a[0] * hist_y1 + active_a[1] * hist_y2) >>> biquad_cfg_pkg::coeff_frac;
        y = w - fb;
        if (y > y_max) begin
            y = y_max;
        end else if (y < y_min) begin
            y = y_min;
        end
        return y[DATA_W-1:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic write_reg(input logic [biquad_cfg_pkg::adr_w-1:0] adr,
                             input logic [31:0] data);
        reg_wr_i  = 1'b1;
        reg_adr_i = adr;
        reg_dat_i = data;
        model_write(adr, data);
        next_cycle();
        reg_wr_i = 1'b0;
    endtask

    // upper bits carry junk that the filter must ignore
    task automatic write_coeff(input logic [biquad_cfg_pkg::adr_w-1:0] adr, input int c);
        write_reg(adr, {14'h2B7, c[17:0]});
    endtask

    // keep samples out of the shadow to active copy window
    task automatic update_by_ctrl();
        write_reg(biquad_cfg_pkg::adr_ctrl, 32'h0000_0001);
        idle(3);
    endtask

    task automatic update_by_global();
        global_update_i = 1'b1;
        model_update();
        next_cycle();
        global_update_i = 1'b0;
        idle(3);
    endtask

    task automatic send_sample(input logic signed [DATA_W-1:0] x);
        dat_valid_i = 1'b1;
        dat_i       = x;
        next_cycle();
        dat_valid_i = 1'b0;
    endtask

    // gaps of 0 to 3 idle cycles, 0 gives back-to-back strobes
    task automatic send_random_samples(input int n);
        for (int i = 0; i < n; i++) begin
            idle(rand_bits(2));
            send_sample(rand_bits(DATA_W));
        end
    endtask

    // compare process, expected values queued as samples enter
    initial begin
        logic [1:0]               vhist;
        logic signed [DATA_W-1:0] y_exp;
        vhist = '0;
        for (int n = 0; !rst_n_i; n++) begin
            if (n > RESET_CYCLES + WAIT_CYCLES) begin
                abort_run("reset was never released");
            end
            @(negedge clk_i);
        end
        forever begin
            @(negedge clk_i);
            assert (dat_valid_o == vhist[1]) else
                abort_run($sformatf("** Error at %0t: dat_valid_o expected %0b, actual %0b",
                                    $time, vhist[1], dat_valid_o));
            if (dat_valid_o) begin
                y_exp = exp_q.pop_front();
                assert (dat_o == y_exp) else
                    abort_run($sformatf("** Error at %0t: dat_o expected %0d, actual %0d",
                                        $time, y_exp, dat_o));
            end
            vhist = {vhist[0], dat_valid_i};
            if (dat_valid_i) begin
                y_exp = ref_filter(dat_i);
                exp_q.push_back(y_exp);
                hist_x2 = hist_x1;
                hist_x1 = dat_i;
                hist_y2 = hist_y1;
                hist_y1 = y_exp;
            end
        end
    end

    initial begin
        rst_n_i         = 1'b0;
        reg_wr_i        = 1'b0;
        reg_adr_i       = '0;
        reg_dat_i       = '0;
        global_update_i = 1'b0;
        dat_valid_i     = 1'b0;
        dat_i           = '0;
        lfsr_state      = 16'd48192;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        next_cycle();

        // reset default passes samples through
        for (int i = 0; i < 8; i++) begin
            send_sample(rand_bits(DATA_W));
        end
        idle(2);

        // shadow writes alone, then a control word update
        write_coeff(biquad_cfg_pkg::adr_b0, 8192);
        write_coeff(biquad_cfg_pkg::adr_b1, 4096);
        write_coeff(biquad_cfg_pkg::adr_b2, -2048);
        write_coeff(biquad_cfg_pkg::adr_a1, -8192);
        write_coeff(biquad_cfg_pkg::adr_a2, 2048);
        send_random_samples(12);
        update_by_ctrl();
        send_random_samples(12);

        // same switch through the global update input
        write_coeff(biquad_cfg_pkg::adr_b0, 16384);
        write_coeff(biquad_cfg_pkg::adr_b1, 16384);
        write_coeff(biquad_cfg_pkg::adr_b2, -4096);
        write_coeff(biquad_cfg_pkg::adr_a1, 0);
        write_coeff(biquad_cfg_pkg::adr_a2, 4096);
        send_random_samples(8);
        update_by_global();
        send_random_samples(12);

        // unmapped addresses and a control word without update
        write_coeff(biquad_cfg_pkg::adr_b0, -12000);
        write_coeff(biquad_cfg_pkg::adr_a1, 6000);
        write_reg(5'h18, 32'h0001_2345);
        write_reg(5'h1C, 32'hFFFF_FFFF);
        write_reg(5'h06, 32'h0000_4000);
        write_reg(biquad_cfg_pkg::adr_ctrl, 32'hFFFF_FFFE);
        send_random_samples(12);
        update_by_ctrl();
        send_random_samples(12);

        // large gain and feedback drive y into saturation
        write_coeff(biquad_cfg_pkg::adr_b0, 131071);
        write_coeff(biquad_cfg_pkg::adr_a1, -131072);
        update_by_ctrl();
        send_random_samples(16);

        // random coefficient sets
        for (int s = 0; s < 6; s++) begin
            for (int k = 0; k < 5; k++) begin
                write_coeff(COEFF_ADR[k], rand_coeff());
            end
            if (s % 2 == 0) begin
                update_by_ctrl();
            end else begin
                update_by_global();
            end
            send_random_samples(40);
        end

        for (int n = 0; n < WAIT_CYCLES && exp_q.size() != 0; n++) begin
            @(posedge clk_i);
        end
        if (exp_q.size() != 0) begin
            abort_run("samples were still outstanding at the end of the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
